//--- logic/clockPkg.sv
package clockPkg;

  // Diagnostic function code of two octal digits
  localparam int funcWidth    = 6;
  localparam int readSelWidth = 3;  // Low octal digit
  localparam int nibbleWidth  = 4;

  localparam int rateWidth  = 2;
  localparam int divWidth   = 2 ** rateWidth - 1;  // Divides by up to 8
  localparam int timeWidth  = 2;
  localparam int burstWidth = 8;

  // Cycles from cycle abort to the forced trap
  localparam int pfForceDelay = 2;

  localparam logic [funcWidth-1:0] fnStop          = 6'o00;
  localparam logic [funcWidth-1:0] fnStart         = 6'o01;
  localparam logic [funcWidth-1:0] fnStep          = 6'o02;
  localparam logic [funcWidth-1:0] fnBurst         = 6'o05;
  localparam logic [funcWidth-1:0] fnLoadBurstLow  = 6'o42;
  localparam logic [funcWidth-1:0] fnLoadBurstHigh = 6'o43;
  localparam logic [funcWidth-1:0] fnLoadMode      = 6'o44;
  localparam logic [funcWidth-1:0] fnLoadCheck     = 6'o45;
  localparam logic [funcWidth-1:0] fnReadBase      = 6'(7'o100);

  typedef struct packed {
    logic [1:0]           sourceSel;  // Kept for readback
    logic [rateWidth-1:0] rateSel;
  } modeFields;

  typedef struct packed {
    logic fmParChk;
    logic cramParChk;
    logic errStopEn;
    logic spare;
  } checkFields;

  // One host nibble decoded per load function
  typedef union packed {
    logic [nibbleWidth-1:0] raw;
    modeFields              mode;
    checkFields             check;
  } ctlData;

endpackage

//--- logic/diagFuncDecode.sv
`timescale 1ns/1ps

module diagFuncDecode (
  input  logic                               CLK,
  input  logic                               reset,
  input  logic                               diagReq,
  input  logic [clockPkg::funcWidth-1:0]     diagFunc,
  input  logic [clockPkg::nibbleWidth-1:0]   diagData,
  input  logic [clockPkg::nibbleWidth-1:0]   readValue,
  output logic                               diagAck,
  output logic [clockPkg::nibbleWidth-1:0]   readData,
  output logic [clockPkg::readSelWidth-1:0]  readSel,
  output logic [clockPkg::nibbleWidth-1:0]   loadValue,
  output logic                               startCmd,
  output logic                               stopCmd,
  output logic                               stepCmd,
  output logic                               burstCmd,
  output logic                               loadLow,
  output logic                               loadHigh,
  output logic                               loadMode,
  output logic                               loadCheck
);
  import clockPkg::*;

  logic accept;
  logic isRead;

  // New request only once the previous ack has dropped
  assign accept  = diagReq & ~diagAck;
  assign readSel = diagFunc[readSelWidth-1:0];
  assign isRead  = diagFunc[funcWidth-1:readSelWidth] == fnReadBase[funcWidth-1:readSelWidth];

  always_ff @(posedge CLK) begin
    if (reset) begin
      diagAck   <= 1'b0;
      startCmd  <= 1'b0;
      stopCmd   <= 1'b0;
      stepCmd   <= 1'b0;
      burstCmd  <= 1'b0;
      loadLow   <= 1'b0;
      loadHigh  <= 1'b0;
      loadMode  <= 1'b0;
      loadCheck <= 1'b0;
    end else begin
      diagAck   <= diagReq;  // Rises after req, falls after req drops
      startCmd  <= accept && diagFunc == fnStart;
      stopCmd   <= accept && diagFunc == fnStop;
      stepCmd   <= accept && diagFunc == fnStep;
      burstCmd  <= accept && diagFunc == fnBurst;
      loadLow   <= accept && diagFunc == fnLoadBurstLow;
      loadHigh  <= accept && diagFunc == fnLoadBurstHigh;
      loadMode  <= accept && diagFunc == fnLoadMode;
      loadCheck <= accept && diagFunc == fnLoadCheck;
    end
  end

  // Data held alongside the strobes
  always_ff @(posedge CLK) begin
    if (accept) begin
      loadValue <= diagData;
    end
    if (accept && isRead) begin
      readData <= readValue;
    end
  end

  ackNeedsReq: assert property (@(posedge CLK) disable iff (reset)
    $rose(diagAck) |-> diagReq);

endmodule

//--- logic/clockGate.sv
`timescale 1ns/1ps

module clockGate (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic                             startCmd,
  input  logic                             stopCmd,
  input  logic                             stepCmd,
  input  logic                             burstCmd,
  input  logic                             loadMode,
  input  logic [clockPkg::nibbleWidth-1:0] loadValue,
  input  logic                             burstZero,
  input  logic                             syncReady,
  input  logic                             holdoff,
  input  logic                             errorStop,
  output logic                             eboxClkEn,
  output logic                             rateTick,
  output logic                             running,
  output logic                             bursting,
  output logic [clockPkg::nibbleWidth-1:0] modeBits
);
  import clockPkg::*;

  ctlData              modeReg;
  logic [divWidth-1:0] divCnt;
  logic [divWidth-1:0] rateMask;
  logic                stepPending;
  logic                wantTick;
  logic                tickNext;

  // One rate tick every 2^rateSel cycles
  assign rateMask = (divWidth'(1) << modeReg.mode.rateSel) - divWidth'(1);
  assign rateTick = (divCnt & rateMask) == rateMask;

  assign wantTick = (((running | (bursting & ~burstZero)) & ~errorStop) | stepPending) & ~stopCmd;
  assign tickNext = rateTick & wantTick & syncReady & ~holdoff;
  assign modeBits = modeReg.raw;

  always_ff @(posedge CLK) begin
    if (reset) begin
      divCnt      <= '0;
      modeReg.raw <= '0;
      eboxClkEn   <= 1'b0;
      running     <= 1'b0;
      bursting    <= 1'b0;
      stepPending <= 1'b0;
    end else begin
      divCnt    <= divCnt + divWidth'(1);
      eboxClkEn <= tickNext;
      if (loadMode) modeReg.raw <= loadValue;

      if (startCmd) begin  // Also restarts after an error stop
        running  <= 1'b1;
        bursting <= 1'b0;
      end else if (errorStop || stopCmd) begin
        running  <= 1'b0;
        bursting <= 1'b0;
      end else if (burstCmd) begin
        running  <= 1'b0;
        bursting <= 1'b1;
      end else if (bursting && burstZero) begin
        bursting <= 1'b0;
      end

      if (stopCmd) stepPending <= 1'b0;
      else if (stepCmd) stepPending <= 1'b1;
      else if (tickNext) stepPending <= 1'b0;  // Step consumed
    end
  end

  noTickAfterHoldoff: assert property (@(posedge CLK) disable iff (reset)
    holdoff |=> !eboxClkEn);

endmodule

//--- logic/burstCounter.sv
`timescale 1ns/1ps

module burstCounter (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic                             loadLow,
  input  logic                             loadHigh,
  input  logic [clockPkg::nibbleWidth-1:0] loadValue,
  input  logic                             bursting,
  input  logic                             eboxClkEn,
  output logic [clockPkg::burstWidth-1:0]  burstCount,
  output logic                             burstZero
);
  import clockPkg::*;

  logic                  countDown;
  logic [burstWidth-1:0] countNext;

  assign countDown = bursting & eboxClkEn & (burstCount != '0);

  always_comb begin
    countNext = burstCount;
    if (countDown) begin
      countNext = burstCount - burstWidth'(1);
    end
  end

  // Looks ahead past the tick in flight
  assign burstZero = countNext == '0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      burstCount <= '0;
    end else if (loadLow) begin
      burstCount[nibbleWidth-1:0] <= loadValue;
    end else if (loadHigh) begin
      burstCount[burstWidth-1:nibbleWidth] <= loadValue;
    end else begin
      burstCount <= countNext;
    end
  end

  // Clock gate stops short of an empty counter
  noUnderflow: assert property (@(posedge CLK) disable iff (reset)
    bursting && eboxClkEn |-> burstCount != '0);

endmodule

//--- logic/syncTimer.sv
`timescale 1ns/1ps

module syncTimer (
  input  logic                           CLK,
  input  logic                           reset,
  input  logic [clockPkg::timeWidth-1:0] cramTime,
  input  logic                           eboxClkEn,
  input  logic                           rateTick,
  output logic                           syncReady
);
  import clockPkg::*;

  logic [timeWidth-1:0] waitCnt;
  logic [timeWidth-1:0] waitEff;

  // A tick reloads the time field in its own cycle
  assign waitEff   = eboxClkEn ? cramTime : waitCnt;
  assign syncReady = waitEff == '0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      waitCnt <= '0;
    end else if (rateTick && !syncReady) begin
      waitCnt <= waitEff - timeWidth'(1);
    end else begin
      waitCnt <= waitEff;
    end
  end

endmodule

//--- logic/faultCtl.sv
`timescale 1ns/1ps

module faultCtl (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic                             pageFail,
  input  logic                             parityErr,
  input  logic                             eboxClkEn,
  input  logic                             loadCheck,
  input  logic [clockPkg::nibbleWidth-1:0] loadValue,
  input  logic                             startCmd,
  output logic                             eboxCycAbort,
  output logic                             force1777,
  output logic                             holdoff,
  output logic                             errorStop,
  output logic [clockPkg::nibbleWidth-1:0] checkBits,
  output logic                             parityLatched
);
  import clockPkg::*;

  ctlData                  checkReg;
  logic                    pfHit;
  logic                    parityCheck;
  logic [pfForceDelay-1:0] pfDelay;

  assign pfHit       = pageFail & eboxClkEn;  // Fail only counts on a tick
  assign parityCheck = checkReg.check.fmParChk | checkReg.check.cramParChk;

  // Trap fires at the end of the delay chain
  assign force1777 = pfDelay[pfForceDelay-1];
  assign holdoff   = pfHit | eboxCycAbort | (|pfDelay);

  assign errorStop = parityLatched & checkReg.check.errStopEn;
  assign checkBits = checkReg.raw;

  always_ff @(posedge CLK) begin
    if (reset) begin
      eboxCycAbort <= 1'b0;
      pfDelay      <= '0;
    end else begin
      eboxCycAbort <= pfHit;
      pfDelay      <= (pfDelay << 1) | pfForceDelay'(eboxCycAbort);
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      checkReg.raw  <= '0;
      parityLatched <= 1'b0;
    end else begin
      if (loadCheck) checkReg.raw <= loadValue;

      if (startCmd) begin
        parityLatched <= 1'b0;
      end else if (parityErr && parityCheck) begin
        parityLatched <= 1'b1;  // Held until the next start
      end
    end
  end

endmodule

//--- logic/diagReadMux.sv
`timescale 1ns/1ps

module diagReadMux (
  input  logic [clockPkg::readSelWidth-1:0] readSel,
  input  logic [clockPkg::burstWidth-1:0]   burstCount,
  input  logic [clockPkg::nibbleWidth-1:0]  modeBits,
  input  logic [clockPkg::nibbleWidth-1:0]  checkBits,
  input  logic                              running,
  input  logic                              bursting,
  input  logic                              errorStop,
  input  logic                              parityLatched,
  input  logic                              force1777,
  input  logic                              eboxClkEn,
  output logic [clockPkg::nibbleWidth-1:0]  readValue
);
  import clockPkg::*;

  always_comb begin
    case (readSel)
      3'd0: readValue = burstCount[nibbleWidth-1:0];
      3'd1: readValue = burstCount[burstWidth-1:nibbleWidth];
      3'd2: readValue = {running, bursting, errorStop, parityLatched};
      3'd3: readValue = modeBits;   // Raw with both fields
      3'd4: readValue = checkBits;
      3'd5: readValue = {eboxClkEn, force1777, 2'b00};
      default: readValue = '0;
    endcase
  end

endmodule

//--- logic/clockCtl.sv
`timescale 1ns/1ps

module clockCtl (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic                             diagReq,
  input  logic [clockPkg::funcWidth-1:0]   diagFunc,
  input  logic [clockPkg::nibbleWidth-1:0] diagData,
  input  logic [clockPkg::timeWidth-1:0]   cramTime,
  input  logic                             pageFail,
  input  logic                             parityErr,
  output logic                             diagAck,
  output logic [clockPkg::nibbleWidth-1:0] readData,
  output logic                             eboxClkEn,
  output logic                             eboxCycAbort,
  output logic                             force1777,
  output logic                             errorStop
);
  import clockPkg::*;

  logic [readSelWidth-1:0] readSel;
  logic [nibbleWidth-1:0]  readValue;
  logic [nibbleWidth-1:0]  loadValue;
  logic [nibbleWidth-1:0]  modeBits;
  logic [nibbleWidth-1:0]  checkBits;
  logic [burstWidth-1:0]   burstCount;
  logic startCmd, stopCmd, stepCmd, burstCmd;
  logic loadLow, loadHigh, loadMode, loadCheck;
  logic burstZero, syncReady, holdoff, rateTick;
  logic running, bursting, parityLatched;

  diagFuncDecode u_diagFuncDecode (
    .CLK, .reset, .diagReq, .diagFunc, .diagData, .readValue,
    .diagAck, .readData, .readSel, .loadValue,
    .startCmd, .stopCmd, .stepCmd, .burstCmd,
    .loadLow, .loadHigh, .loadMode, .loadCheck
  );

  clockGate u_clockGate (
    .CLK, .reset, .startCmd, .stopCmd, .stepCmd, .burstCmd, .loadMode, .loadValue,
    .burstZero, .syncReady, .holdoff, .errorStop,
    .eboxClkEn, .rateTick, .running, .bursting, .modeBits
  );

  burstCounter u_burstCounter (
    .CLK, .reset, .loadLow, .loadHigh, .loadValue, .bursting, .eboxClkEn,
    .burstCount, .burstZero
  );

  syncTimer u_syncTimer (
    .CLK, .reset, .cramTime, .eboxClkEn, .rateTick, .syncReady
  );

  faultCtl u_faultCtl (
    .CLK, .reset, .pageFail, .parityErr, .eboxClkEn, .loadCheck, .loadValue, .startCmd,
    .eboxCycAbort, .force1777, .holdoff, .errorStop, .checkBits, .parityLatched
  );

  diagReadMux u_diagReadMux (
    .readSel, .burstCount, .modeBits, .checkBits, .running, .bursting,
    .errorStop, .parityLatched, .force1777, .eboxClkEn, .readValue
  );

endmodule

//--- tests/clockCtlChecks.sv
`timescale 1ns/1ps

module clockCtlChecks (
  input logic CLK,
  input logic reset,
  input logic diagReq,
  input logic diagAck,
  input logic pageFail,
  input logic eboxClkEn,
  input logic eboxCycAbort,
  input logic force1777,
  input logic errorStop
);
  import clockPkg::*;

  int failCount = 0;

  task automatic countFailure(input string what);
    failCount++;
    $display("FAILED at %0t ns: %s", $time, what);
  endtask

  // Ack is the request delayed by one cycle
  ackFollowsReq: assert property (@(posedge CLK) disable iff (reset)
    diagAck == $past(diagReq))
    else countFailure("diagAck does not follow diagReq by one cycle");

  ackHeldForReq: assert property (@(posedge CLK) disable iff (reset)
    diagAck && !diagReq |=> !diagAck)
    else countFailure("diagAck held after diagReq dropped");

  abortOnTick: assert property (@(posedge CLK) disable iff (reset)
    pageFail && eboxClkEn |=> eboxCycAbort)
    else countFailure("page fail on a tick gave no cycle abort");

  abortNeedsTick: assert property (@(posedge CLK) disable iff (reset)
    $rose(eboxCycAbort) |-> $past(pageFail && eboxClkEn))
    else countFailure("cycle abort without a page fail on a tick");

  trapAfterAbort: assert property (@(posedge CLK) disable iff (reset)
    eboxCycAbort |-> ##pfForceDelay force1777)
    else countFailure("force1777 missing after cycle abort");

  // Abort through trap is one holdoff window
  noTickInHoldoff: assert property (@(posedge CLK) disable iff (reset)
    eboxCycAbort |-> !eboxClkEn [*pfForceDelay+1])
    else countFailure("tick between cycle abort and force1777");

  errorStopHalts: assert property (@(posedge CLK) disable iff (reset)
    errorStop |=> !eboxClkEn)
    else countFailure("tick while errorStop is high");

endmodule

//--- tests/clockCtlTb.sv
`timescale 1ns/1ps

module clockCtlTb;
  import clockPkg::*;

  logic CLK, reset, diagReq, pageFail, parityErr;
  logic [funcWidth-1:0] diagFunc;
  logic [nibbleWidth-1:0] diagData, readData, rd;
  logic [timeWidth-1:0] cramTime;
  logic diagAck, eboxClkEn, eboxCycAbort, force1777, errorStop;
  logic [7:0] lfsrState, r, c, n, v [4];
  int cycleCount = 0, tickCount = 0, lastTickCycle = 0, lastGap = 0;
  int errors = 0, checks = 0, errBefore, t0, mark, w;

  clockCtl u_clockCtl (.*);
  clockCtlChecks u_checks (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Tick monitor sampled away from the active edge
  always @(negedge CLK) begin
    cycleCount++;
    if (eboxClkEn) begin
      lastGap = cycleCount - lastTickCycle;
      lastTickCycle = cycleCount;
      tickCount++;
    end
  end

  function automatic logic [7:0] lfsrStep(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic randomBits(input int count, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      bits = {bits[6:0], lfsrState[0]};
    end
  endtask

  task automatic abortRun(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic checkEqual(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // Four-phase host transfer that returns the latched read nibble
  task automatic transfer(input logic [5:0] func, input logic [3:0] data,
                          output logic [3:0] rdata);
    int waitCnt;
    @(posedge CLK);
    diagReq <= 1'b1;
    diagFunc <= func;
    diagData <= data;
    waitCnt = 0;
    do begin
      @(posedge CLK);
      waitCnt++;
      if (waitCnt > 20) abortRun("Timeout waiting for diagAck to rise");
    end while (!diagAck);
    rdata = readData;
    diagReq <= 1'b0;
    waitCnt = 0;
    do begin
      @(posedge CLK);
      waitCnt++;
      if (waitCnt > 20) abortRun("Timeout waiting for diagAck to fall");
    end while (diagAck);
  endtask

  task automatic waitTicks(input int target, input int limit);
    int waitCnt = 0;
    while (tickCount < target) begin
      @(posedge CLK);
      waitCnt++;
      if (waitCnt > limit) abortRun("Timeout waiting for clock ticks");
    end
  endtask

  task automatic idle(input int cycles);
    for (int i = 0; i < cycles; i++) @(posedge CLK);
  endtask

  task automatic finishTest(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - errBefore);
    errBefore = errors;
  endtask

  initial begin
    lfsrState = 8'd34;
    reset = 1'b1;
    diagReq = 1'b0;
    diagFunc = '0;
    diagData = '0;
    cramTime = '0;
    pageFail = 1'b0;
    parityErr = 1'b0;
    errBefore = 0;
    idle(4);
    reset <= 1'b0;

    for (int i = 0; i < 4; i++) randomBits(4, v[i]);
    v[2][1:0] = 2'd0;  // Keep rate fast for later tests
    transfer(fnLoadBurstLow, v[0][3:0], rd);
    transfer(fnLoadBurstHigh, v[1][3:0], rd);
    transfer(fnLoadMode, v[2][3:0], rd);
    transfer(fnLoadCheck, v[3][3:0], rd);
    transfer(fnReadBase + 6'd0, 4'h0, rd);  // Read 0 is also stop
    checkEqual(rd, v[0][3:0], "burst low readback");
    transfer(fnReadBase + 6'd1, 4'h0, rd);  // Read 1 also starts
    checkEqual(rd, v[1][3:0], "burst high readback");
    transfer(fnReadBase + 6'd3, 4'h0, rd);
    checkEqual(rd, v[2][3:0], "mode readback");
    transfer(fnReadBase + 6'd4, 4'h0, rd);
    checkEqual(rd, v[3][3:0], "check readback");
    transfer(fnStop, 4'h0, rd);
    transfer(fnLoadCheck, 4'h0, rd);
    finishTest(1, "handshake and loads");

    t0 = tickCount;
    transfer(fnStep, 4'h0, rd);
    waitTicks(t0 + 1, 100);
    idle(30);
    checkEqual(tickCount - t0, 1, "ticks from one step");
    finishTest(2, "single step");

    transfer(fnLoadMode, 4'h0, rd);
    for (int k = 0; k < 2; k++) begin
      randomBits(6, n);
      if (k == 1) n = 8'd0;
      transfer(fnLoadBurstLow, n[3:0], rd);
      transfer(fnLoadBurstHigh, n[7:4], rd);
      t0 = tickCount;
      transfer(fnBurst, 4'h0, rd);
      waitTicks(t0 + n, 2000);
      idle(30);
      checkEqual(tickCount - t0, n, "burst tick count");
      transfer(fnReadBase + 6'd2, 4'h0, rd);
      checkEqual(rd, 0, "status after burst");
      transfer(fnReadBase + 6'd0, 4'h0, rd);
      checkEqual(rd, 0, "burst low after burst");
      transfer(fnReadBase + 6'd1, 4'h0, rd);
      checkEqual(rd, 0, "burst high after burst");
      transfer(fnStop, 4'h0, rd);
    end
    finishTest(3, "burst");

    for (int k = 0; k < 2; k++) begin
      randomBits(2, r);
      randomBits(2, c);
      randomBits(2, n);
      cramTime <= c[1:0];
      transfer(fnLoadMode, {n[1:0], r[1:0]}, rd);
      transfer(fnStart, 4'h0, rd);
      waitTicks(tickCount + 2, 400);
      for (int g = 0; g < 3; g++) begin
        waitTicks(tickCount + 1, 200);
        checkEqual(lastGap, (c + 1) << r, "tick spacing");
      end
      transfer(fnStop, 4'h0, rd);
      t0 = tickCount;
      idle(50);
      checkEqual(tickCount - t0, 0, "ticks after stop");
    end
    finishTest(4, "run rate and stretch");

    cramTime <= '0;
    transfer(fnLoadMode, 4'h0, rd);
    transfer(fnStart, 4'h0, rd);
    waitTicks(tickCount + 3, 100);
    pageFail <= 1'b1;  // Clock runs every cycle here
    @(posedge CLK);
    pageFail <= 1'b0;
    w = 0;
    while (!eboxCycAbort) begin
      @(posedge CLK);
      w++;
      if (w > 20) abortRun("Timeout waiting for eboxCycAbort");
    end
    mark = cycleCount;
    t0 = tickCount;
    w = 0;
    while (!force1777) begin
      @(posedge CLK);
      w++;
      if (w > 20) abortRun("Timeout waiting for force1777");
    end
    checkEqual(cycleCount - mark, pfForceDelay, "abort to force1777 delay");
    checkEqual(tickCount - t0, 0, "ticks during holdoff");
    transfer(fnStop, 4'h0, rd);
    finishTest(5, "page fail");

    transfer(fnLoadCheck, 4'b1010, rd);  // fmParChk and errStopEn
    transfer(fnStart, 4'h0, rd);
    waitTicks(tickCount + 3, 100);
    parityErr <= 1'b1;
    @(posedge CLK);
    parityErr <= 1'b0;
    w = 0;
    while (!errorStop) begin
      @(posedge CLK);
      w++;
      if (w > 20) abortRun("Timeout waiting for errorStop");
    end
    idle(2);
    t0 = tickCount;
    idle(30);
    checkEqual(tickCount - t0, 0, "ticks after error stop");
    transfer(fnLoadCheck, 4'b1000, rd);
    transfer(fnStart, 4'h0, rd);
    parityErr <= 1'b1;
    @(posedge CLK);
    parityErr <= 1'b0;
    t0 = tickCount;
    idle(20);
    checkEqual(errorStop, 0, "errorStop with stop disabled");
    checkEqual(tickCount > t0, 1, "clock runs with stop disabled");
    transfer(fnReadBase + 6'd2, 4'h0, rd);
    checkEqual(rd, 4'b1001, "status with parity latched");
    transfer(fnStart, 4'h0, rd);
    transfer(fnReadBase + 6'd2, 4'h0, rd);
    checkEqual(rd, 4'b1000, "status after start clears latch");
    transfer(fnStop, 4'h0, rd);
    transfer(fnLoadCheck, 4'h0, rd);
    finishTest(6, "error stop");

    idle(5);
    $display("tests 6, checks %0d, errors %0d, assertion failures %0d",
             checks, errors, u_checks.failCount);
    if (errors + u_checks.failCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- clockCtl.f
logic/clockPkg.sv
logic/diagFuncDecode.sv
logic/clockGate.sv
logic/burstCounter.sv
logic/syncTimer.sv
logic/faultCtl.sv
logic/diagReadMux.sv
logic/clockCtl.sv
tests/clockCtlChecks.sv
tests/clockCtlTb.sv

//--- Bender.yml
package:
  name: clockCtl

sources:
  - logic/clockPkg.sv
  - logic/diagFuncDecode.sv
  - logic/clockGate.sv
  - logic/burstCounter.sv
  - logic/syncTimer.sv
  - logic/faultCtl.sv
  - logic/diagReadMux.sv
  - logic/clockCtl.sv
  - target: test
    files:
      - tests/clockCtlChecks.sv
      - tests/clockCtlTb.sv
